//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_sram_subsys
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_TEXT ?= Testbench passed
VFLAGS    ?= --timing --assert

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FLIST) --top-module $(TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FLIST) --top-module $(TOP) \
		--Mdir $(BUILD_DIR) -o V$(TOP)

sim: build
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "$(PASS_TEXT)" $(LOG) || { echo "simulation did not pass, see $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- flist.f
src/bus_pkg.sv
src/sram_pkg.sv
src/wb_port.sv
src/sram_arbiter.sv
src/sram_phy.sv
src/sram_subsys_top.sv
sim/sram_model.sv
sim/tb_sram_subsys.sv

//--- sim/sram_model.sv
module sram_model
    import bus_pkg::*, sram_pkg::*;
(
    inout  word_t      ram_data,
    input  sram_addr_t ram_addr,
    input  sram_be_t   ram_be_n,
    input  logic       ram_ce_n,
    input  logic       ram_oe_n,
    input  logic       ram_we_n
);

    timeunit 1ns;
    timeprecision 100ps;

    localparam int DEPTH = 2 ** SRAM_ADDR_W;

    word_t mem [DEPTH];
    logic  read_en;

    // power-up contents, a function of the full word address
    function automatic word_t fill_word(sram_addr_t a);
        return {~a[11:0], a};
    endfunction

    initial begin
        for (int i = 0; i < DEPTH; i++) begin
            mem[i] = fill_word(sram_addr_t'(i));
        end
    end

    assign read_en  = !ram_ce_n && !ram_oe_n && ram_we_n && (ram_be_n != '1);
    assign ram_data = read_en ? mem[ram_addr] : 'z;

    // write lands once the bus has settled after we_n falls
    always @(negedge ram_we_n) begin
        #1;
        if (!ram_ce_n && !ram_we_n) begin
            for (int b = 0; b < SRAM_BE_W; b++) begin
                if (!ram_be_n[b])
                    mem[ram_addr][8*b +: 8] = ram_data[8*b +: 8];
            end
        end
    end

endmodule

//--- sim/tb_sram_subsys.sv
module tb_sram_subsys
    import bus_pkg::*, sram_pkg::*;
;

    timeunit 1ns;
    timeprecision 100ps;

    localparam bus_addr_t WIN_BASE       = 32'h0000_2000;
    localparam int        NUM_ENTRIES    = 19;
    localparam int        NUM_PAIRS      = 2;
    localparam int        NUM_RANDOM     = 64;
    localparam int        ACK_LATENCY    = 5;
    localparam int        TIMEOUT_CYCLES = 20 + 12 * (NUM_ENTRIES + NUM_PAIRS + NUM_RANDOM);
    localparam logic      RD             = 1'b0;
    localparam logic      WR             = 1'b1;

    logic       clk = 1'b0;
    logic       rst;
    logic       ib_cyc, ib_stb, ib_we, ib_ack;
    bus_addr_t  ib_adr;
    word_t      ib_dat_w, ib_dat_r;
    sel_t       ib_sel;
    logic       db_cyc, db_stb, db_we, db_ack;
    bus_addr_t  db_adr;
    word_t      db_dat_w, db_dat_r;
    sel_t       db_sel;
    wire word_t ram_data;
    sram_addr_t ram_addr;
    sram_be_t   ram_be_n;
    logic       ram_ce_n, ram_oe_n, ram_we_n;

    // stimulus table, one column per field
    port_idx_t stim_port   [NUM_ENTRIES];
    logic      stim_we     [NUM_ENTRIES];
    bus_addr_t stim_adr    [NUM_ENTRIES];
    sel_t      stim_sel    [NUM_ENTRIES];
    word_t     stim_wdata  [NUM_ENTRIES];
    logic      stim_paired [NUM_ENTRIES];   // starts together with the next entry
    int        num_stim;

    word_t shadow [256];
    int    cycle_cnt;
    int    ib_ack_cnt, db_ack_cnt;
    int    ib_ack_exp, db_ack_exp;
    int    seed = 32'h7bb98787;

    always #2 clk = ~clk;

    sram_subsys_top i_sram_subsys_top (.*);

    sram_model u_sram_model (.*);

    task automatic stop_on_error(input string what);
        $display("%s", what);
        $display("Testbench failed");
        $fatal(1, "stopped at first error");
    endtask

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (ib_ack)
            ib_ack_cnt <= ib_ack_cnt + 1;
        if (db_ack)
            db_ack_cnt <= db_ack_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES)
            stop_on_error($sformatf("timeout: test not done after %0d cycles", TIMEOUT_CYCLES));
    end

    task automatic check_word(input string name, input word_t expected, input word_t actual);
        if (actual !== expected)
            stop_on_error($sformatf("[FAIL] %0t %s: expected %h, got %h",
                                    $time, name, expected, actual));
    endtask

    task automatic check_pins(input string name, input sram_be_t be_n, input logic ce_n,
                              input logic oe_n, input logic we_n);
        if ({ram_be_n, ram_ce_n, ram_oe_n, ram_we_n} !== {be_n, ce_n, oe_n, we_n})
            stop_on_error($sformatf("[FAIL] %0t %s: expected %b, got %b", $time, name,
                                    {be_n, ce_n, oe_n, we_n},
                                    {ram_be_n, ram_ce_n, ram_oe_n, ram_we_n}));
    endtask

    task automatic check_count(input string name, input int expected, input int actual);
        if (actual != expected)
            stop_on_error($sformatf("[FAIL] %0t %s: expected %0d, got %0d",
                                    $time, name, expected, actual));
    endtask

    function automatic word_t power_up_word(sram_addr_t a);
        return {~a[11:0], a};   // same fill as the sram model
    endfunction

    function automatic word_t merge_bytes(word_t old_w, word_t new_w, sel_t sel);
        word_t w;
        w = old_w;
        for (int b = 0; b < 4; b++) begin
            if (sel[b])
                w[8*b +: 8] = new_w[8*b +: 8];
        end
        return w;
    endfunction

    // update the shadow, hand back what a read would return
    task automatic predict(input logic we, input bus_addr_t adr, input sel_t sel,
                           input word_t wdata, output word_t exp);
        if (we)
            shadow[adr[9:2]] = merge_bytes(shadow[adr[9:2]], wdata, sel);
        exp = shadow[adr[9:2]];
    endtask

    task automatic drive_port(input port_idx_t port, input logic on, input logic we,
                              input bus_addr_t adr, input sel_t sel, input word_t wdata);
        if (port == PORT_INSTR) begin
            ib_cyc   <= on;
            ib_stb   <= on;
            ib_we    <= we;
            ib_adr   <= adr;
            ib_sel   <= sel;
            ib_dat_w <= wdata;
        end else begin
            db_cyc   <= on;
            db_stb   <= on;
            db_we    <= we;
            db_adr   <= adr;
            db_sel   <= sel;
            db_dat_w <= wdata;
        end
    endtask

    // one classic cycle; lat counts from the edge that samples stb to the ack edge
    task automatic wb_access(input port_idx_t port, input logic we, input bus_addr_t adr,
                             input sel_t sel, input word_t wdata, output word_t rdata,
                             output int lat, output int at);
        int   n;
        logic seen;
        n    = 0;
        seen = 1'b0;
        @(posedge clk);
        drive_port(port, 1'b1, we, adr, sel, wdata);
        while (!seen) begin
            @(posedge clk);
            n++;
            seen = (port == PORT_INSTR) ? ib_ack : db_ack;
        end
        rdata = (port == PORT_INSTR) ? ib_dat_r : db_dat_r;
        at    = cycle_cnt;
        lat   = n - 2;
        drive_port(port, 1'b0, 1'b0, '0, '0, '0);
        if (port == PORT_INSTR)
            ib_ack_exp++;
        else
            db_ack_exp++;
    endtask

    task automatic run_single(input port_idx_t port, input logic we, input bus_addr_t adr,
                              input sel_t sel, input word_t wdata);
        word_t exp, got;
        int    lat, at;
        predict(we, adr, sel, wdata, exp);
        wb_access(port, we, adr, sel, wdata, got, lat, at);
        check_count("ack latency", ACK_LATENCY, lat);
        if (!we)
            check_word(port == PORT_INSTR ? "ib_dat_r" : "db_dat_r", exp, got);
    endtask

    task automatic run_pair(input int a, input int b);
        int    ie, de;
        word_t d_exp, i_exp, f_exp, d_got, i_got, f_got;
        int    d_lat, i_lat, f_lat, d_at, i_at, f_at;
        ie = (stim_port[a] == PORT_INSTR) ? a : b;
        de = (ie == a) ? b : a;
        if (stim_port[ie] == stim_port[de])
            stop_on_error("paired stimulus entries use the same port");
        // data wins the tie, instr gets the next slot, then the data read-back
        predict(stim_we[de], stim_adr[de], stim_sel[de], stim_wdata[de], d_exp);
        predict(stim_we[ie], stim_adr[ie], stim_sel[ie], stim_wdata[ie], i_exp);
        predict(RD, stim_adr[de], '1, '0, f_exp);
        fork
            begin
                wb_access(PORT_DATA, stim_we[de], stim_adr[de], stim_sel[de],
                          stim_wdata[de], d_got, d_lat, d_at);
                wb_access(PORT_DATA, RD, stim_adr[de], '1, '0, f_got, f_lat, f_at);
            end
            wb_access(PORT_INSTR, stim_we[ie], stim_adr[ie], stim_sel[ie],
                      stim_wdata[ie], i_got, i_lat, i_at);
        join
        if (!stim_we[de])
            check_word("db_dat_r", d_exp, d_got);
        if (!stim_we[ie])
            check_word("ib_dat_r", i_exp, i_got);
        check_word("db_dat_r", f_exp, f_got);
        if (!(d_at < i_at && i_at < f_at))
            stop_on_error($sformatf("paired order wrong: data %0d, instr %0d, data again %0d",
                                    d_at, i_at, f_at));
        repeat (2) @(posedge clk);
        check_count("ib_ack count", ib_ack_exp, ib_ack_cnt);
        check_count("db_ack count", db_ack_exp, db_ack_cnt);
    endtask

    task automatic add_entry(input port_idx_t port, input logic we, input bus_addr_t adr,
                             input sel_t sel, input word_t wdata, input logic paired);
        stim_port[num_stim]   = port;
        stim_we[num_stim]     = we;
        stim_adr[num_stim]    = adr;
        stim_sel[num_stim]    = sel;
        stim_wdata[num_stim]  = wdata;
        stim_paired[num_stim] = paired;
        num_stim++;
    endtask

    task automatic load_table();
        add_entry(PORT_DATA,  WR, WIN_BASE + 32'h00, 4'hf, 32'h1234_5678, 1'b0);
        add_entry(PORT_DATA,  RD, WIN_BASE + 32'h00, 4'hf, 32'h0,         1'b0);
        // byte merges, one to three lanes
        add_entry(PORT_DATA,  WR, WIN_BASE + 32'h04, 4'hf, 32'ha5a5_5a5a, 1'b0);
        add_entry(PORT_DATA,  WR, WIN_BASE + 32'h04, 4'h1, 32'h0000_00c3, 1'b0);
        add_entry(PORT_DATA,  WR, WIN_BASE + 32'h04, 4'h6, 32'h00be_ef00, 1'b0);
        add_entry(PORT_DATA,  RD, WIN_BASE + 32'h04, 4'hf, 32'h0,         1'b0);
        add_entry(PORT_DATA,  WR, WIN_BASE + 32'h04, 4'hb, 32'hdead_0077, 1'b0);
        add_entry(PORT_DATA,  RD, WIN_BASE + 32'h04, 4'hf, 32'h0,         1'b0);
        add_entry(PORT_DATA,  WR, WIN_BASE + 32'h08, 4'h8, 32'h9900_0000, 1'b0);
        add_entry(PORT_DATA,  RD, WIN_BASE + 32'h08, 4'hf, 32'h0,         1'b0);
        add_entry(PORT_INSTR, RD, WIN_BASE + 32'h00, 4'hf, 32'h0,         1'b0);
        add_entry(PORT_INSTR, RD, WIN_BASE + 32'h04, 4'hf, 32'h0,         1'b0);
        add_entry(PORT_DATA,  WR, WIN_BASE + 32'h10, 4'hf, 32'hcafe_f00d, 1'b0);
        add_entry(PORT_INSTR, RD, WIN_BASE + 32'h10, 4'hf, 32'h0,         1'b0);
        add_entry(PORT_DATA,  WR, WIN_BASE + 32'h20, 4'hf, 32'h0bad_c0de, 1'b1);
        add_entry(PORT_INSTR, RD, WIN_BASE + 32'h10, 4'hf, 32'h0,         1'b0);
        add_entry(PORT_INSTR, RD, WIN_BASE + 32'h20, 4'hf, 32'h0,         1'b1);
        add_entry(PORT_DATA,  WR, WIN_BASE + 32'h20, 4'h3, 32'h0000_1111, 1'b0);
        add_entry(PORT_INSTR, RD, WIN_BASE + 32'h08, 4'hf, 32'h0,         1'b0);
    endtask

    initial begin
        int        idx;
        int        r;
        logic      rnd_we;
        bus_addr_t rnd_adr;
        rst <= 1'b1;
        drive_port(PORT_INSTR, 1'b0, 1'b0, '0, '0, '0);
        drive_port(PORT_DATA, 1'b0, 1'b0, '0, '0, '0);
        for (int i = 0; i < 256; i++) begin
            shadow[i] = power_up_word(sram_addr_t'(WIN_BASE[21:2] + i));
        end
        repeat (10) @(posedge clk);
        rst <= 1'b0;

        // idle bus after reset
        repeat (5) begin
            @(posedge clk);
            check_pins("sram pins after reset", '1, 1'b1, 1'b1, 1'b1);
        end
        check_count("ib_ack count", 0, ib_ack_cnt);
        check_count("db_ack count", 0, db_ack_cnt);

        load_table();
        idx = 0;
        while (idx < NUM_ENTRIES) begin
            if (stim_paired[idx]) begin
                run_pair(idx, idx + 1);
                idx += 2;
            end else begin
                run_single(stim_port[idx], stim_we[idx], stim_adr[idx], stim_sel[idx],
                           stim_wdata[idx]);
                idx++;
            end
        end

        for (int n = 0; n < NUM_RANDOM; n++) begin
            r       = $random(seed);
            rnd_we  = r[1];
            rnd_adr = WIN_BASE + bus_addr_t'({r[15:8], 2'b00});
            run_single(r[0], rnd_we, rnd_adr, rnd_we ? r[19:16] : 4'hf,
                       word_t'($random(seed)));
        end

        repeat (2) @(posedge clk);
        check_count("ib_ack count", ib_ack_exp, ib_ack_cnt);
        check_count("db_ack count", db_ack_exp, db_ack_cnt);
        check_pins("sram pins at end", '1, 1'b1, 1'b1, 1'b1);
        $display("Testbench passed");
        $finish;
    end

endmodule

//--- src/bus_pkg.sv
package bus_pkg;

    localparam int BUS_DATA_W = 32;
    localparam int BUS_ADDR_W = 32;
    localparam int BUS_SEL_W  = BUS_DATA_W / 8;

    // one data word on any bus path
    typedef logic [BUS_DATA_W-1:0] word_t;

    // byte address as seen by the masters
    typedef logic [BUS_ADDR_W-1:0] bus_addr_t;

    // wishbone byte selects, active high
    typedef logic [BUS_SEL_W-1:0] sel_t;

    // which master owns a request
    typedef logic port_idx_t;

    localparam port_idx_t PORT_INSTR = 1'b0;
    localparam port_idx_t PORT_DATA  = 1'b1;

endpackage

//--- src/sram_arbiter.sv
module sram_arbiter
    import bus_pkg::*, sram_pkg::*;
(
    input  logic       clk,
    input  logic       rst,

    // instruction side
    input  logic       i_req,
    input  logic       i_we,
    input  sram_addr_t i_addr,
    input  sram_be_t   i_be_n,
    input  word_t      i_wdata,
    output logic       i_done,
    output word_t      i_rdata,

    // data side
    input  logic       d_req,
    input  logic       d_we,
    input  sram_addr_t d_addr,
    input  sram_be_t   d_be_n,
    input  word_t      d_wdata,
    output logic       d_done,
    output word_t      d_rdata,

    // command to the sequencer
    output logic       start,
    output logic       cmd_we,
    output sram_addr_t cmd_addr,
    output sram_be_t   cmd_be_n,
    output word_t      cmd_wdata,
    input  logic       busy,
    input  logic       finish,
    input  word_t      rd_data
);

    port_idx_t grant;
    logic      pending;    // command issued and finish not yet back
    logic      i_skipped;  // instr lost a tie and owns the next slot
    logic      i_want;
    logic      d_want;
    logic      issue;
    port_idx_t pick;

    // req of the port being finished stays high one more cycle
    assign i_want = i_req && !(finish && grant == PORT_INSTR);
    assign d_want = d_req && !(finish && grant == PORT_DATA);

    assign pick  = (i_want && (!d_want || i_skipped)) ? PORT_INSTR : PORT_DATA;
    assign issue = (i_want || d_want) && !busy && (!pending || finish);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            grant     <= PORT_INSTR;
            pending   <= 1'b0;
            i_skipped <= 1'b0;
            start     <= 1'b0;
        end else begin
            start <= 1'b0;
            if (issue) begin
                grant     <= pick;
                pending   <= 1'b1;
                start     <= 1'b1;
                i_skipped <= (pick == PORT_DATA) && i_want;
            end else if (finish) begin
                pending <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (issue) begin
            cmd_we    <= (pick == PORT_INSTR) ? i_we    : d_we;
            cmd_addr  <= (pick == PORT_INSTR) ? i_addr  : d_addr;
            cmd_be_n  <= (pick == PORT_INSTR) ? i_be_n  : d_be_n;
            cmd_wdata <= (pick == PORT_INSTR) ? i_wdata : d_wdata;
        end
    end

    assign i_done  = finish && (grant == PORT_INSTR);
    assign d_done  = finish && (grant == PORT_DATA);
    assign i_rdata = rd_data;
    assign d_rdata = rd_data;

    a_start_not_busy: assert property (
        @(posedge clk) disable iff (rst) $rose(start) |-> !busy
    );

    // a finish only completes an issued command of a port still requesting
    a_done_to_req: assert property (
        @(posedge clk) disable iff (rst)
            finish |-> pending && ((grant == PORT_INSTR) ? i_req : d_req)
    );

endmodule

//--- src/sram_phy.sv
module sram_phy
    import bus_pkg::*, sram_pkg::*;
(
    input  logic       clk,
    input  logic       rst,

    // command side
    input  logic       start,
    input  logic       cmd_we,
    input  sram_addr_t cmd_addr,
    input  sram_be_t   cmd_be_n,
    input  word_t      cmd_wdata,
    output logic       busy,
    output logic       finish,
    output word_t      rd_data,

    // sram pins
    inout  word_t      ram_data,
    output sram_addr_t ram_addr,
    output sram_be_t   ram_be_n,
    output logic       ram_ce_n,
    output logic       ram_oe_n,
    output logic       ram_we_n
);

    phy_state_t            state;
    logic [SRAM_CNT_W-1:0] cnt;
    logic                  drive_en;
    word_t                 wdata;
    logic                  last_cycle;

    assign last_cycle = (state == PHY_ACCESS) && (cnt == SRAM_CNT_W'(SRAM_ACCESS_CYCLES - 1));

    // a start sampled during recovery lands after it, so only ACCESS blocks
    assign busy = (state == PHY_ACCESS);

    assign ram_data = drive_en ? wdata : 'z;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state    <= PHY_IDLE;
            cnt      <= '0;
            finish   <= 1'b0;
            drive_en <= 1'b0;
            ram_be_n <= '1;
            ram_ce_n <= 1'b1;
            ram_oe_n <= 1'b1;
            ram_we_n <= 1'b1;
        end else begin
            finish <= 1'b0;
            case (state)
                PHY_IDLE: begin
                    if (start) begin
                        state    <= PHY_ACCESS;
                        cnt      <= '0;
                        drive_en <= cmd_we;
                        ram_be_n <= cmd_be_n;
                        ram_ce_n <= 1'b0;
                        ram_oe_n <= cmd_we;
                        ram_we_n <= !cmd_we;
                    end
                end
                PHY_ACCESS: begin
                    if (last_cycle) begin
                        state    <= PHY_RECOVER;
                        finish   <= 1'b1;
                        drive_en <= 1'b0;
                        ram_be_n <= '1;
                        ram_ce_n <= 1'b1;
                        ram_oe_n <= 1'b1;
                        ram_we_n <= 1'b1;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                PHY_RECOVER: begin
                    state <= PHY_IDLE;
                end
                default: begin
                    state <= PHY_IDLE;
                end
            endcase
        end
    end

    // address and write data only change on a new start
    always_ff @(posedge clk) begin
        if (state == PHY_IDLE && start) begin
            ram_addr <= cmd_addr;
            wdata    <= cmd_wdata;
        end
    end

    always_ff @(posedge clk) begin
        if (last_cycle && !ram_oe_n) begin
            rd_data <= ram_data;   // end of last read cycle
        end
    end

    a_no_oe_we: assert property (
        @(posedge clk) disable iff (rst) !(!ram_oe_n && !ram_we_n)
    );

    a_drive_on_write: assert property (
        @(posedge clk) disable iff (rst) drive_en |-> !ram_we_n
    );

endmodule

//--- src/sram_pkg.sv
package sram_pkg;

    // word address width of the external part
    localparam int SRAM_ADDR_W = 20;
    localparam int SRAM_BE_W   = 4;

    // strobe low time in clk cycles
    localparam int SRAM_ACCESS_CYCLES = 2;
    localparam int SRAM_CNT_W = $clog2(SRAM_ACCESS_CYCLES + 1);

    typedef logic [SRAM_ADDR_W-1:0] sram_addr_t;

    // byte enables, active low like the pins
    typedef logic [SRAM_BE_W-1:0] sram_be_t;

    typedef enum logic [1:0] {
        PHY_IDLE,
        PHY_ACCESS,
        PHY_RECOVER   // strobes high for one cycle between accesses
    } phy_state_t;

endpackage

//--- src/sram_subsys_top.sv
module sram_subsys_top
    import bus_pkg::*, sram_pkg::*;
(
    input  logic       clk,
    input  logic       rst,

    // instruction fetch port
    input  logic       ib_cyc,
    input  logic       ib_stb,
    input  logic       ib_we,
    input  bus_addr_t  ib_adr,
    input  word_t      ib_dat_w,
    input  sel_t       ib_sel,
    output word_t      ib_dat_r,
    output logic       ib_ack,

    // data port
    input  logic       db_cyc,
    input  logic       db_stb,
    input  logic       db_we,
    input  bus_addr_t  db_adr,
    input  word_t      db_dat_w,
    input  sel_t       db_sel,
    output word_t      db_dat_r,
    output logic       db_ack,

    // external sram
    inout  word_t      ram_data,
    output sram_addr_t ram_addr,
    output sram_be_t   ram_be_n,
    output logic       ram_ce_n,
    output logic       ram_oe_n,
    output logic       ram_we_n
);

    logic       i_req, i_we, i_done;
    sram_addr_t i_addr;
    sram_be_t   i_be_n;
    word_t      i_wdata, i_rdata;

    logic       d_req, d_we, d_done;
    sram_addr_t d_addr;
    sram_be_t   d_be_n;
    word_t      d_wdata, d_rdata;

    logic       start, cmd_we, busy, finish;
    sram_addr_t cmd_addr;
    sram_be_t   cmd_be_n;
    word_t      cmd_wdata, rd_data;

    wb_port u_ib_port (
        .clk, .rst,
        .cyc(ib_cyc), .stb(ib_stb), .we(ib_we), .adr(ib_adr),
        .dat_w(ib_dat_w), .sel(ib_sel), .dat_r(ib_dat_r), .ack(ib_ack),
        .req(i_req), .req_we(i_we), .req_addr(i_addr), .req_sel(i_be_n),
        .req_wdata(i_wdata), .done(i_done), .done_rdata(i_rdata)
    );

    wb_port u_db_port (
        .clk, .rst,
        .cyc(db_cyc), .stb(db_stb), .we(db_we), .adr(db_adr),
        .dat_w(db_dat_w), .sel(db_sel), .dat_r(db_dat_r), .ack(db_ack),
        .req(d_req), .req_we(d_we), .req_addr(d_addr), .req_sel(d_be_n),
        .req_wdata(d_wdata), .done(d_done), .done_rdata(d_rdata)
    );

    sram_arbiter u_arbiter (
        .clk, .rst,
        .i_req, .i_we, .i_addr, .i_be_n, .i_wdata, .i_done, .i_rdata,
        .d_req, .d_we, .d_addr, .d_be_n, .d_wdata, .d_done, .d_rdata,
        .start, .cmd_we, .cmd_addr, .cmd_be_n, .cmd_wdata,
        .busy, .finish, .rd_data
    );

    sram_phy u_phy (
        .clk, .rst,
        .start, .cmd_we, .cmd_addr, .cmd_be_n, .cmd_wdata,
        .busy, .finish, .rd_data,
        .ram_data, .ram_addr, .ram_be_n, .ram_ce_n, .ram_oe_n, .ram_we_n
    );

endmodule

//--- src/wb_port.sv
module wb_port
    import bus_pkg::*, sram_pkg::*;
(
    input  logic       clk,
    input  logic       rst,

    // wishbone classic slave
    input  logic       cyc,
    input  logic       stb,
    input  logic       we,
    input  bus_addr_t  adr,
    input  word_t      dat_w,
    input  sel_t       sel,
    output word_t      dat_r,
    output logic       ack,

    // towards the arbiter
    output logic       req,
    output logic       req_we,
    output sram_addr_t req_addr,
    output sram_be_t   req_sel,
    output word_t      req_wdata,
    input  logic       done,
    input  word_t      done_rdata
);

    logic take;

    // only accept while neither holding a request nor acking one
    assign take = cyc && stb && !req && !ack;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            req <= 1'b0;
            ack <= 1'b0;
        end else begin
            ack <= 1'b0;
            if (take) begin
                req <= 1'b1;
            end else if (req && done) begin
                req <= 1'b0;
                ack <= 1'b1;
            end
        end
    end

    // request payload, held until done
    always_ff @(posedge clk) begin
        if (take) begin
            req_we    <= we;
            req_addr  <= adr[SRAM_ADDR_W+1:2]; // byte -> word address
            req_sel   <= ~sel;
            req_wdata <= dat_w;
        end
    end

    always_ff @(posedge clk) begin
        if (req && done) begin
            dat_r <= done_rdata;
        end
    end

    // master holds the cycle open until it sees ack
    a_ack_in_cycle: assert property (
        @(posedge clk) disable iff (rst) ack |-> (cyc && stb)
    );

endmodule
